//--- files.f
vec_op_pkg.sv
vec_types_pkg.sv
vaddsub.sv
vec_issue.sv
vec_op_queue.sv
vec_exec.sv
vec_alu_top.sv
tb_vec_checker.sv
tb_vec_alu.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_vec_alu
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?=
PASS_TEXT  ?= Verification passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing $(SIM_FLAGS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_vec_alu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_vec_alu
    import vec_op_pkg::*;
    import vec_types_pkg::*;
();

    localparam int          NUM_REQ    = 600;
    localparam int          WAIT_LIMIT = 200;   // cycles per wait
    localparam logic [31:0] LFSR_SEED  = 32'd79481;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_ready;
    vec_req_t    req;
    logic        resp_valid;
    logic        resp_ready;
    vec_resp_t   resp;
    int          err_cnt;
    int          req_cnt;
    int          resp_cnt;
    int          pending;
    logic [31:0] lfsr;
    logic        timed_out;
    logic        took;
    logic [63:0] gap;
    int          waited;

    vec_alu_top dut (
        .clk_i        (clk),
        .rst_i        (rst),
        .req_valid_i  (req_valid),
        .req_ready_o  (req_ready),
        .req_i        (req),
        .resp_valid_o (resp_valid),
        .resp_ready_i (resp_ready),
        .resp_o       (resp)
    );

    tb_vec_checker u_checker (
        .clk_i        (clk),
        .rst_i        (rst),
        .req_valid_i  (req_valid),
        .req_ready_i  (req_ready),
        .req_i        (req),
        .resp_valid_i (resp_valid),
        .resp_ready_i (resp_ready),
        .resp_i       (resp),
        .err_cnt_o    (err_cnt),
        .req_cnt_o    (req_cnt),
        .resp_cnt_o   (resp_cnt),
        .pending_o    (pending)
    );

    always #4 clk = ~clk;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int nbits, output logic [63:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[62:0], lfsr[0]};
        end
    endtask

    // all ones now and then so carries ripple up to every element boundary
    task automatic pick_operand(output bus64_t v);
        logic [63:0] sel;
        take_bits(2, sel);
        if (sel == 0) begin
            v = '1;
        end else begin
            take_bits(64, v);
        end
    endtask

    task automatic build_request(input int idx);
        logic [63:0] r;
        bus64_t      v;
        take_bits(4, r);
        if (r < 14) begin
            req.opcode = opcode_t'(r % 7);
        end else begin
            take_bits(3, r);
            req.opcode = opcode_t'(7 + r);   // 7..14 decode as illegal
        end
        take_bits(2, r);
        req.sew = sew_t'(r);
        take_bits(1, r);
        req.use_mask = r[0];
        pick_operand(v);
        req.vs1 = v;
        pick_operand(v);
        req.vs2 = v;
        take_bits(8, r);
        req.vm  = mask8_t'(r);
        req.tag = tag_t'(idx);
    endtask

    // one clock with ready sampled mid-cycle and new back-pressure 1 ns after the edge
    task automatic step_cycle(output logic accepted);
        logic [63:0] r;
        @(negedge clk);
        accepted = req_valid & req_ready;
        @(posedge clk);
        #1;
        take_bits(3, r);
        resp_ready = (r >= 3);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b0;
        lfsr       = LFSR_SEED;
        timed_out  = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (4) step_cycle(took);   // idle cycles where the output must stay quiet
        for (int n = 0; n < NUM_REQ && !timed_out; n++) begin
            build_request(n);
            req_valid = 1'b1;
            took      = 1'b0;
            waited    = 0;
            while (!took && !timed_out) begin
                step_cycle(took);
                waited++;
                if (!took && waited >= WAIT_LIMIT) begin
                    $display("Timeout: request %0d not accepted after %0d cycles", n, waited);
                    timed_out = 1'b1;
                end
            end
            req_valid = 1'b0;
            take_bits(3, gap);
            if (gap == 0) begin
                step_cycle(took);
            end
        end
        waited = 0;
        while (pending != 0 && !timed_out) begin
            step_cycle(took);
            waited++;
            if (pending != 0 && waited >= WAIT_LIMIT) begin
                $display("Timeout: %0d responses still missing after %0d cycles", pending, waited);
                timed_out = 1'b1;
            end
        end
        $display("requests %0d, responses %0d, errors %0d, timeouts %0d",
                 req_cnt, resp_cnt, err_cnt, timed_out);
        if (timed_out || err_cnt != 0 || resp_cnt != NUM_REQ) begin
            $display("Verification failed");
        end else begin
            $display("Verification passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_vec_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_vec_checker
    import vec_op_pkg::*;
    import vec_types_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_i,
    input  wire logic      req_valid_i,
    input  wire logic      req_ready_i,
    input  wire vec_req_t  req_i,
    input  wire logic      resp_valid_i,
    input  wire logic      resp_ready_i,
    input  wire vec_resp_t resp_i,
    output int             err_cnt_o,
    output int             req_cnt_o,
    output int             resp_cnt_o,
    output int             pending_o
);

    vec_resp_t model_q[$];   // expected responses in request order
    vec_resp_t exp_resp;

    function automatic bus64_t width_mask(input int w);
        return (w == 64) ? '1 : (64'd1 << w) - 64'd1;
    endfunction

    // element-wise reference in 65-bit math so bit w holds carry or borrow
    function automatic vec_resp_t model_result(input vec_req_t r);
        vec_resp_t   res;
        int          w;
        int          n;
        logic [64:0] a;
        logic [64:0] b;
        logic [64:0] s;
        logic        cin;
        logic        mask_op;
        w       = 8 << r.sew;
        n       = 64 / w;
        mask_op = (r.opcode == OPC_VMADC) || (r.opcode == OPC_VMSBC);
        res.tag     = r.tag;
        res.illegal = (r.opcode > OPC_VMSBC);
        res.vd      = mask_op ? '1 : '0;   // upper mask bits read as one
        if (!res.illegal) begin
            for (int e = 0; e < n; e++) begin
                a   = {1'b0, (r.vs2 >> (e * w)) & width_mask(w)};
                b   = {1'b0, (r.vs1 >> (e * w)) & width_mask(w)};
                cin = r.vm[e];
                case (r.opcode)
                    OPC_VADD:  s = a + b;
                    OPC_VSUB:  s = a - b;
                    OPC_VRSUB: s = b - a;
                    OPC_VADC:  s = a + b + 65'(cin);
                    OPC_VSBC:  s = a - b - 65'(cin);
                    OPC_VMADC: s = a + b + 65'(cin & r.use_mask);
                    default:   s = a - b - 65'(cin & r.use_mask);   // VMSBC
                endcase
                if (mask_op) begin
                    res.vd[e] = s[w];
                end else begin
                    res.vd = res.vd | ((s[63:0] & width_mask(w)) << (e * w));
                end
            end
        end
        return res;
    endfunction

    always @(posedge clk_i) begin
        if (rst_i) begin
            model_q.delete();
        end else begin
            if (resp_valid_i && model_q.size() == 0) begin
                err_cnt_o++;
                $display("Response valid at %0t with no request outstanding", $time);
            end
            // ready may only drop once the issue stage and the queue are both full
            if (!req_ready_i && model_q.size() < OP_QUEUE_DEPTH + 1) begin
                err_cnt_o++;
                $display("Request ready low at %0t with only %0d requests in flight",
                         $time, model_q.size());
            end
            if (resp_valid_i && resp_ready_i && model_q.size() > 0) begin
                exp_resp = model_q.pop_front();
                resp_cnt_o++;
                if (resp_i !== exp_resp) begin
                    err_cnt_o++;
                    $display("Mismatch at %0t: tag %0h vd %h illegal %0b, expected %0h %h %0b",
                             $time, resp_i.tag, resp_i.vd, resp_i.illegal,
                             exp_resp.tag, exp_resp.vd, exp_resp.illegal);
                end
            end
            if (req_valid_i && req_ready_i) begin
                model_q.push_back(model_result(req_i));
                req_cnt_o++;
            end
        end
        pending_o = model_q.size();
    end

endmodule

`default_nettype wire

//--- vec_alu_top.sv
`timescale 1ns/1ns
`default_nettype none

module vec_alu_top
    import vec_types_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_i,
    input  wire logic      req_valid_i,
    output logic           req_ready_o,
    input  wire vec_req_t  req_i,
    output logic           resp_valid_o,
    input  wire logic      resp_ready_i,
    output vec_resp_t      resp_o
);

    logic        iss_valid;
    logic        iss_ready;
    vec_issued_t iss_entry;
    logic        q_valid;
    logic        q_ready;
    vec_issued_t q_entry;

    vec_issue u_issue (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (req_i),
        .iss_valid_o (iss_valid),
        .iss_ready_i (iss_ready),
        .iss_entry_o (iss_entry)
    );

    // in-order buffer between decode and the adder
    vec_op_queue u_queue (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wr_valid_i (iss_valid),
        .wr_ready_o (iss_ready),
        .wr_entry_i (iss_entry),
        .rd_valid_o (q_valid),
        .rd_ready_i (q_ready),
        .rd_entry_o (q_entry)
    );

    vec_exec u_exec (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .op_valid_i   (q_valid),
        .op_ready_o   (q_ready),
        .op_entry_i   (q_entry),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_o       (resp_o)
    );

endmodule

`default_nettype wire

//--- vec_exec.sv
`timescale 1ns/1ns
`default_nettype none

module vec_exec
    import vec_op_pkg::*;
    import vec_types_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_i,
    input  wire logic        op_valid_i,
    output logic             op_ready_o,
    input  wire vec_issued_t op_entry_i,
    output logic             resp_valid_o,
    input  wire logic        resp_ready_i,
    output vec_resp_t        resp_o
);

    bus64_t    vd_calc;
    vec_resp_t resp_d;
    vec_resp_t resp_q;
    logic      resp_valid_q;
    logic      pop;

    // pop when the result slot is free or drains this cycle
    assign op_ready_o = ~resp_valid_q | resp_ready_i;
    assign pop        = op_valid_i & op_ready_o;

    vaddsub u_vaddsub (
        .instr_type_i (op_entry_i.instr),
        .sew_i        (op_entry_i.sew),
        .data_vs1_i   (op_entry_i.vs1),
        .data_vs2_i   (op_entry_i.vs2),
        .data_vm_i    (op_entry_i.vm),
        .use_mask_i   (op_entry_i.use_mask),
        .data_vd_o    (vd_calc)
    );

    always_comb begin
        resp_d.tag     = op_entry_i.tag;
        resp_d.illegal = (op_entry_i.instr == VILLEGAL);
        resp_d.vd      = resp_d.illegal ? '0 : vd_calc;   // illegal ops return zero
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            resp_valid_q <= 1'b0;
        end else if (op_ready_o) begin
            resp_valid_q <= op_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop) begin
            resp_q <= resp_d;
        end
    end

    assign resp_valid_o = resp_valid_q;
    assign resp_o       = resp_q;

endmodule

`default_nettype wire

//--- vec_op_queue.sv
`timescale 1ns/1ns
`default_nettype none

module vec_op_queue
    import vec_op_pkg::*;
    import vec_types_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_i,
    input  wire logic        wr_valid_i,
    output logic             wr_ready_o,
    input  wire vec_issued_t wr_entry_i,
    output logic             rd_valid_o,
    input  wire logic        rd_ready_i,
    output vec_issued_t      rd_entry_o
);

    typedef enum logic [1:0] {Q_EMPTY, Q_PARTIAL, Q_FULL} q_state_t;
    typedef logic [OP_QUEUE_PTR_W-1:0] qptr_t;

    q_state_t    state_q;
    q_state_t    state_d;
    qptr_t       wr_ptr_q;
    qptr_t       rd_ptr_q;
    qptr_t       wr_ptr_nxt;
    qptr_t       rd_ptr_nxt;
    vec_issued_t mem_q [OP_QUEUE_DEPTH];
    logic        push;
    logic        pop;

    function automatic qptr_t ptr_inc(input qptr_t p);
        return (p == qptr_t'(OP_QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign wr_ready_o = (state_q != Q_FULL);
    assign rd_valid_o = (state_q != Q_EMPTY);
    assign rd_entry_o = mem_q[rd_ptr_q];   // head of queue

    assign push       = wr_valid_i & wr_ready_o;
    assign pop        = rd_valid_o & rd_ready_i;
    assign wr_ptr_nxt = ptr_inc(wr_ptr_q);
    assign rd_ptr_nxt = ptr_inc(rd_ptr_q);

    always_comb begin
        case ({push, pop})
            2'b10:   state_d = (wr_ptr_nxt == rd_ptr_q) ? Q_FULL : Q_PARTIAL;
            2'b01:   state_d = (rd_ptr_nxt == wr_ptr_q) ? Q_EMPTY : Q_PARTIAL;
            default: state_d = state_q;   // idle, or push and pop together
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q  <= Q_EMPTY;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            state_q <= state_d;
            if (push) wr_ptr_q <= wr_ptr_nxt;
            if (pop)  rd_ptr_q <= rd_ptr_nxt;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= wr_entry_i;
        end
    end

endmodule

`default_nettype wire

//--- vec_issue.sv
`timescale 1ns/1ns
`default_nettype none

module vec_issue
    import vec_op_pkg::*;
    import vec_types_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_i,
    input  wire logic        req_valid_i,
    output logic             req_ready_o,
    input  wire vec_req_t    req_i,
    output logic             iss_valid_o,
    input  wire logic        iss_ready_i,
    output vec_issued_t      iss_entry_o
);

    instr_type_t op_dec;
    vec_issued_t entry_d;
    vec_issued_t entry_q;
    logic        entry_valid_q;
    logic        accept;

    // anything outside the opcode table decodes to VILLEGAL
    always_comb begin
        case (req_i.opcode)
            OPC_VADD:  op_dec = VADD;
            OPC_VSUB:  op_dec = VSUB;
            OPC_VRSUB: op_dec = VRSUB;
            OPC_VADC:  op_dec = VADC;
            OPC_VSBC:  op_dec = VSBC;
            OPC_VMADC: op_dec = VMADC;
            OPC_VMSBC: op_dec = VMSBC;
            default:   op_dec = VILLEGAL;
        endcase
    end

    always_comb begin
        entry_d.tag      = req_i.tag;
        entry_d.instr    = op_dec;
        entry_d.sew      = req_i.sew;
        entry_d.use_mask = req_i.use_mask;
        entry_d.vs1      = req_i.vs1;
        entry_d.vs2      = req_i.vs2;
        entry_d.vm       = req_i.vm;
    end

    // take a new request when empty or when the held one leaves this cycle
    assign req_ready_o = ~entry_valid_q | iss_ready_i;
    assign accept      = req_valid_i & req_ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            entry_valid_q <= 1'b0;
        end else if (req_ready_o) begin
            entry_valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            entry_q <= entry_d;
        end
    end

    assign iss_valid_o = entry_valid_q;
    assign iss_entry_o = entry_q;

endmodule

`default_nettype wire

//--- vaddsub.sv
`timescale 1ns/1ns
`default_nettype none

module vaddsub
    import vec_op_pkg::*;
    import vec_types_pkg::*;
(
    input  wire instr_type_t instr_type_i,
    input  wire sew_t        sew_i,
    input  wire bus64_t      data_vs1_i,
    input  wire bus64_t      data_vs2_i,
    input  wire mask8_t      data_vm_i,    // one bit per element
    input  wire logic        use_mask_i,
    output bus64_t           data_vd_o
);

    logic is_sub;
    logic is_rsub;
    logic is_vadc;
    logic is_vsbc;
    logic is_vmadc;
    logic is_vmsbc;
    logic is_subtraction;
    logic invert_vs1;
    logic mask_cin;      // vm[e] enters as carry in
    logic fold_borrow;   // vm[e] is added to vs1 before the inversion

    logic [2:0]      bpe_m1;       // bytes per element minus one
    logic [7:0]      elem_start;
    logic [7:0]      elem_end;
    logic [7:0]      elem_vm;      // mask bit of the element owning the byte
    logic [7:0][8:0] fold;         // vs1 bytes with borrow folded in
    logic [7:0][7:0] data_a;
    logic [7:0][7:0] data_b;
    logic [7:0][8:0] result;
    mask8_t          carry_elem;
    mask8_t          borrow_elem;
    bus64_t          sum;

    assign is_sub   = (instr_type_i == VSUB);
    assign is_rsub  = (instr_type_i == VRSUB);
    assign is_vadc  = (instr_type_i == VADC);
    assign is_vsbc  = (instr_type_i == VSBC);
    assign is_vmadc = (instr_type_i == VMADC);
    assign is_vmsbc = (instr_type_i == VMSBC);

    assign is_subtraction = is_sub | is_rsub | is_vsbc | is_vmsbc;
    assign invert_vs1     = is_sub | is_vsbc | is_vmsbc;   // rsub flips vs2 instead
    assign mask_cin       = is_vadc | (is_vmadc & use_mask_i);
    assign fold_borrow    = is_vsbc | (is_vmsbc & use_mask_i);

    always_comb begin
        case (sew_i)
            SEW_8:   bpe_m1 = 3'd0;
            SEW_16:  bpe_m1 = 3'd1;
            SEW_32:  bpe_m1 = 3'd3;
            default: bpe_m1 = 3'd7;
        endcase
    end

    // where each byte sits inside its element
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            elem_start[i] = ((3'(i) & bpe_m1) == 3'd0);
            elem_end[i]   = ((3'(i) & bpe_m1) == bpe_m1);
            elem_vm[i]    = data_vm_i[i >> sew_i];
        end
    end

    // vs1 plus the borrow per element with the same byte chaining as the adder
    always_comb begin
        logic cin;
        cin = 1'b0;
        for (int i = 0; i < 8; i++) begin
            if (elem_start[i]) cin = fold_borrow & elem_vm[i];
            fold[i] = {1'b0, data_vs1_i[8*i +: 8]} + 9'(cin);
            cin     = fold[i][8];
        end
    end

    // the eight byte adders
    // carry chains inside an element and restarts from the operation at each boundary
    always_comb begin
        logic cin;
        cin         = 1'b0;
        carry_elem  = '1;   // slots past the last element read as one
        borrow_elem = '1;
        for (int i = 0; i < 8; i++) begin
            data_a[i] = is_rsub ? ~data_vs2_i[8*i +: 8] : data_vs2_i[8*i +: 8];
            data_b[i] = invert_vs1 ? ~fold[i][7:0] : fold[i][7:0];
            if (elem_start[i]) begin
                cin = is_subtraction ? 1'b1 : (mask_cin & elem_vm[i]);
            end
            result[i]        = {1'b0, data_a[i]} + {1'b0, data_b[i]} + 9'(cin);
            cin              = result[i][8];
            sum[8*i +: 8]    = result[i][7:0];
            if (elem_end[i]) begin
                carry_elem[i >> sew_i] = result[i][8];
                // a folded vs1 that wrapped to zero always borrows
                borrow_elem[i >> sew_i] = ~result[i][8] | fold[i][8];
            end
        end
    end

    always_comb begin
        if (is_vmadc) begin
            data_vd_o = {{(VEC_BITS-MASK_BITS){1'b1}}, carry_elem};
        end else if (is_vmsbc) begin
            data_vd_o = {{(VEC_BITS-MASK_BITS){1'b1}}, borrow_elem};
        end else begin
            data_vd_o = sum;
        end
    end

endmodule

`default_nettype wire

//--- vec_types_pkg.sv
`default_nettype none

package vec_types_pkg;
    import vec_op_pkg::*;

    localparam int VEC_BITS  = 64;
    localparam int MASK_BITS = 8;   // one bit per byte slot
    localparam int TAG_BITS  = 4;

    typedef logic [VEC_BITS-1:0]  bus64_t;
    typedef logic [MASK_BITS-1:0] mask8_t;
    typedef logic [TAG_BITS-1:0]  tag_t;

    // the code is also log2 of the bytes per element
    typedef logic [1:0] sew_t;
    localparam sew_t SEW_8  = 2'd0;
    localparam sew_t SEW_16 = 2'd1;
    localparam sew_t SEW_32 = 2'd2;
    localparam sew_t SEW_64 = 2'd3;

    typedef struct packed {
        tag_t    tag;
        opcode_t opcode;
        sew_t    sew;
        logic    use_mask;
        bus64_t  vs1;
        bus64_t  vs2;
        mask8_t  vm;
    } vec_req_t;

    typedef struct packed {
        tag_t        tag;
        instr_type_t instr;     // opcode after decode
        sew_t        sew;
        logic        use_mask;
        bus64_t      vs1;
        bus64_t      vs2;
        mask8_t      vm;
    } vec_issued_t;

    typedef struct packed {
        tag_t   tag;
        bus64_t vd;
        logic   illegal;
    } vec_resp_t;

endpackage

`default_nettype wire

//--- vec_op_pkg.sv
`default_nettype none

package vec_op_pkg;

    // raw opcode as carried by a request
    typedef logic [3:0] opcode_t;

    localparam opcode_t OPC_VADD  = 4'd0;
    localparam opcode_t OPC_VSUB  = 4'd1;
    localparam opcode_t OPC_VRSUB = 4'd2;
    localparam opcode_t OPC_VADC  = 4'd3;
    localparam opcode_t OPC_VSBC  = 4'd4;
    localparam opcode_t OPC_VMADC = 4'd5;
    localparam opcode_t OPC_VMSBC = 4'd6;  // 7..15 are illegal

    // decoded operation as seen by the adder
    typedef enum logic [2:0] {
        VADD,
        VSUB,
        VRSUB,
        VADC,
        VSBC,
        VMADC,
        VMSBC,
        VILLEGAL
    } instr_type_t;

    localparam int OP_QUEUE_DEPTH = 4;
    localparam int OP_QUEUE_PTR_W = $clog2(OP_QUEUE_DEPTH);

endpackage

`default_nettype wire
